// File: dcache_pkg.sv
package dcache_pkg;

    // word address split into set index and tag
    localparam int ADDR_W   = 17;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = ADDR_W - INDEX_W;

    // one 32-bit word per line, byte enables
    localparam int DATA_W   = 32;
    localparam int MASK_W   = DATA_W / 8;

    // geometry
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int NUM_WAYS = 2;

    // controller states
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOOKUP      = 3'd1,
        CACHE_WRITE = 3'd2,
        MEM_READ    = 3'd3,
        MEM_WRITE   = 3'd4,
        DONE        = 3'd5
    } ctrl_state_t;

endpackage

// File: dcache_if.sv
`timescale 1ns/1ps

// write port of one way array
interface sram_wr_if;

    logic                           wr_en;
    logic [dcache_pkg::INDEX_W-1:0] wr_index;
    logic [dcache_pkg::TAG_W-1:0]   wr_tag;
    logic [dcache_pkg::DATA_W-1:0]  wr_data;
    logic [dcache_pkg::MASK_W-1:0]  wr_mask;

    modport ctrl (
        output wr_en,
        output wr_index,
        output wr_tag,
        output wr_data,
        output wr_mask
    );

    modport array (
        input  wr_en,
        input  wr_index,
        input  wr_tag,
        input  wr_data,
        input  wr_mask
    );

endinterface

// File: cache_way_ram.sv
`timescale 1ns/1ps

module cache_way_ram (
    input  logic                           clk_i,
    sram_wr_if.array                       wr,
    input  logic                           rd_en_i,
    input  logic [dcache_pkg::INDEX_W-1:0] rd_index_i,
    output logic [dcache_pkg::TAG_W-1:0]   rd_tag_o,
    output logic [dcache_pkg::DATA_W-1:0]  rd_data_o
);

    logic [dcache_pkg::TAG_W-1:0]  tag_mem  [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::DATA_W-1:0] data_mem [dcache_pkg::NUM_SETS];

    // write port, tag always updated with the line
    always_ff @(posedge clk_i) begin
        if (wr.wr_en) begin
            tag_mem[wr.wr_index] <= wr.wr_tag;
            for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
                if (wr.wr_mask[b]) begin
                    data_mem[wr.wr_index][8*b +: 8] <= wr.wr_data[8*b +: 8];
                end
            end
        end
    end

    // read port, outputs hold between reads
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_tag_o  <= tag_mem[rd_index_i];
            rd_data_o <= data_mem[rd_index_i];
        end
    end

endmodule

// File: cache_meta.sv
`timescale 1ns/1ps

module cache_meta (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [dcache_pkg::INDEX_W-1:0]  index_i,
    input  logic                            upd_way_i,
    input  logic                            upd_valid_i,
    input  logic                            upd_dirty_i,
    input  logic                            dirty_val_i,
    input  logic                            lru_upd_i,
    input  logic                            lru_way_i,
    output logic [dcache_pkg::NUM_WAYS-1:0] valid_o,
    output logic [dcache_pkg::NUM_WAYS-1:0] dirty_o,
    output logic                            lru_o
);

    logic [dcache_pkg::NUM_SETS-1:0] valid_q [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::NUM_SETS-1:0] dirty_q [dcache_pkg::NUM_WAYS];

    // per set, the way to replace next
    logic [dcache_pkg::NUM_SETS-1:0] lru_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            // valid only ever gets set, lines are never invalidated
            if (upd_valid_i) begin
                valid_q[upd_way_i][index_i] <= 1'b1;
            end
            if (upd_dirty_i) begin
                dirty_q[upd_way_i][index_i] <= dirty_val_i;
            end
            if (lru_upd_i) begin
                lru_q[index_i] <= lru_way_i;
            end
        end
    end

    // addressed set, no clock in the path
    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            valid_o[w] = valid_q[w][index_i];
            dirty_o[w] = dirty_q[w][index_i];
        end
    end

    assign lru_o = lru_q[index_i];

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // core side
    input  logic                            core_sel_i,
    input  logic [dcache_pkg::ADDR_W-1:0]   core_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]   core_wdata_i,
    input  logic [dcache_pkg::MASK_W-1:0]   core_mask_i,
    output logic [dcache_pkg::DATA_W-1:0]   core_rdata_o,
    output logic                            core_stall_o,
    // memory side
    output logic [dcache_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic                            mem_valid_o,
    output logic [dcache_pkg::DATA_W-1:0]   mem_wdata_o,
    output logic [dcache_pkg::MASK_W-1:0]   mem_wstrb_o,
    input  logic [dcache_pkg::DATA_W-1:0]   mem_rdata_i,
    input  logic                            mem_ready_i,
    // way arrays
    sram_wr_if.ctrl                         way0_wr,
    sram_wr_if.ctrl                         way1_wr,
    output logic                            rd_en_o,
    output logic [dcache_pkg::INDEX_W-1:0]  rd_index_o,
    input  logic [dcache_pkg::TAG_W-1:0]    rd_tag0_i,
    input  logic [dcache_pkg::DATA_W-1:0]   rd_data0_i,
    input  logic [dcache_pkg::TAG_W-1:0]    rd_tag1_i,
    input  logic [dcache_pkg::DATA_W-1:0]   rd_data1_i,
    // metadata
    output logic [dcache_pkg::INDEX_W-1:0]  meta_index_o,
    output logic                            meta_upd_way_o,
    output logic                            meta_upd_valid_o,
    output logic                            meta_upd_dirty_o,
    output logic                            meta_dirty_val_o,
    output logic                            meta_lru_upd_o,
    output logic                            meta_lru_way_o,
    input  logic [dcache_pkg::NUM_WAYS-1:0] meta_valid_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0] meta_dirty_i,
    input  logic                            meta_lru_i
);

    logic [dcache_pkg::INDEX_W-1:0] req_index;
    logic [dcache_pkg::TAG_W-1:0]   req_tag;
    logic                           req_write;
    logic                           req_full;

    dcache_pkg::ctrl_state_t state_q, state_d;

    // read issued last cycle / compare result registered
    logic rd_pend_q;
    logic cmp_vld_q;
    logic hit0_q;
    logic hit1_q;

    logic                          tgt_way_q, tgt_way_d;
    logic [dcache_pkg::DATA_W-1:0] wdata_q, wdata_d;
    logic [dcache_pkg::MASK_W-1:0] wmask_q, wmask_d;
    logic [dcache_pkg::DATA_W-1:0] rdata_q, rdata_d;
    logic [dcache_pkg::ADDR_W-1:0] mem_addr_q, mem_addr_d;
    logic [dcache_pkg::DATA_W-1:0] mem_wdata_q, mem_wdata_d;
    logic [dcache_pkg::MASK_W-1:0] mem_wstrb_q, mem_wstrb_d;

    logic                          victim_way;
    logic                          victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]  victim_tag;
    logic [dcache_pkg::DATA_W-1:0] victim_data;
    logic [dcache_pkg::DATA_W-1:0] merged;

    // the core holds its request, so it is used directly
    assign req_index = core_addr_i[dcache_pkg::INDEX_W-1:0];
    assign req_tag   = core_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::INDEX_W];
    assign req_write = |core_mask_i;
    assign req_full  = &core_mask_i;

    assign victim_way   = meta_lru_i;
    assign victim_dirty = meta_valid_i[victim_way] && meta_dirty_i[victim_way];
    assign victim_tag   = victim_way ? rd_tag1_i : rd_tag0_i;
    assign victim_data  = victim_way ? rd_data1_i : rd_data0_i;

    // masked bytes from the core, rest from memory; a read keeps the memory word
    always_comb begin
        for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
            merged[8*b +: 8] = core_mask_i[b] ? core_wdata_i[8*b +: 8] : mem_rdata_i[8*b +: 8];
        end
    end

    always_comb begin
        state_d        = state_q;
        tgt_way_d      = tgt_way_q;
        wdata_d        = wdata_q;
        wmask_d        = wmask_q;
        rdata_d        = rdata_q;
        mem_addr_d     = mem_addr_q;
        mem_wdata_d    = mem_wdata_q;
        mem_wstrb_d    = mem_wstrb_q;
        meta_lru_upd_o = 1'b0;
        meta_lru_way_o = 1'b0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (core_sel_i) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end

            dcache_pkg::LOOKUP: begin
                if (cmp_vld_q) begin
                    if (hit0_q || hit1_q) begin
                        tgt_way_d = hit1_q;
                        if (req_write) begin
                            wdata_d = core_wdata_i;
                            wmask_d = core_mask_i;
                            state_d = dcache_pkg::CACHE_WRITE;
                        end else begin
                            rdata_d        = hit1_q ? rd_data1_i : rd_data0_i;
                            meta_lru_upd_o = 1'b1;
                            meta_lru_way_o = ~hit1_q;
                            state_d        = dcache_pkg::DONE;
                        end
                    end else begin
                        tgt_way_d = victim_way;
                        if (victim_dirty) begin
                            mem_addr_d  = {victim_tag, req_index};
                            mem_wdata_d = victim_data;
                            mem_wstrb_d = '1;
                            state_d     = dcache_pkg::MEM_WRITE;
                        end else if (req_full) begin
                            // whole word replaced, nothing to fetch
                            wdata_d = core_wdata_i;
                            wmask_d = core_mask_i;
                            state_d = dcache_pkg::CACHE_WRITE;
                        end else begin
                            mem_addr_d  = core_addr_i;
                            mem_wdata_d = '0;
                            mem_wstrb_d = '0;
                            state_d     = dcache_pkg::MEM_READ;
                        end
                    end
                end
            end

            dcache_pkg::MEM_WRITE: begin
                if (mem_ready_i) begin
                    if (req_full) begin
                        wdata_d = core_wdata_i;
                        wmask_d = core_mask_i;
                        state_d = dcache_pkg::CACHE_WRITE;
                    end else begin
                        mem_addr_d  = core_addr_i;
                        mem_wdata_d = '0;
                        mem_wstrb_d = '0;
                        state_d     = dcache_pkg::MEM_READ;
                    end
                end
            end

            dcache_pkg::MEM_READ: begin
                if (mem_ready_i) begin
                    wdata_d = merged;
                    wmask_d = '1;
                    state_d = dcache_pkg::CACHE_WRITE;
                end
            end

            dcache_pkg::CACHE_WRITE: begin
                meta_lru_upd_o = 1'b1;
                meta_lru_way_o = ~tgt_way_q;
                // a filled read goes back for a fresh lookup
                state_d = req_write ? dcache_pkg::DONE : dcache_pkg::LOOKUP;
            end

            dcache_pkg::DONE: begin
                state_d = dcache_pkg::IDLE;
            end

            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= dcache_pkg::IDLE;
            rd_pend_q <= 1'b0;
            cmp_vld_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_pend_q <= rd_en_o;
            cmp_vld_q <= (state_q == dcache_pkg::LOOKUP) && rd_pend_q;
        end
    end

    always_ff @(posedge clk_i) begin
        tgt_way_q   <= tgt_way_d;
        wdata_q     <= wdata_d;
        wmask_q     <= wmask_d;
        rdata_q     <= rdata_d;
        mem_addr_q  <= mem_addr_d;
        mem_wdata_q <= mem_wdata_d;
        mem_wstrb_q <= mem_wstrb_d;
        // tag compare registered one cycle after the array read
        if (rd_pend_q) begin
            hit0_q <= meta_valid_i[0] && (rd_tag0_i == req_tag);
            hit1_q <= meta_valid_i[1] && (rd_tag1_i == req_tag);
        end
    end

    // read from idle, or again after a fill
    assign rd_en_o = ((state_q == dcache_pkg::IDLE) && core_sel_i) ||
                     ((state_q == dcache_pkg::LOOKUP) && !rd_pend_q && !cmp_vld_q);
    assign rd_index_o = req_index;

    assign way0_wr.wr_en    = (state_q == dcache_pkg::CACHE_WRITE) && !tgt_way_q;
    assign way0_wr.wr_index = req_index;
    assign way0_wr.wr_tag   = req_tag;
    assign way0_wr.wr_data  = wdata_q;
    assign way0_wr.wr_mask  = wmask_q;

    assign way1_wr.wr_en    = (state_q == dcache_pkg::CACHE_WRITE) && tgt_way_q;
    assign way1_wr.wr_index = req_index;
    assign way1_wr.wr_tag   = req_tag;
    assign way1_wr.wr_data  = wdata_q;
    assign way1_wr.wr_mask  = wmask_q;

    assign meta_index_o     = req_index;
    assign meta_upd_way_o   = tgt_way_q;
    assign meta_upd_valid_o = (state_q == dcache_pkg::CACHE_WRITE);
    assign meta_upd_dirty_o = (state_q == dcache_pkg::CACHE_WRITE);
    assign meta_dirty_val_o = req_write;

    assign mem_valid_o = (state_q == dcache_pkg::MEM_READ) || (state_q == dcache_pkg::MEM_WRITE);
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;
    assign mem_wstrb_o = mem_wstrb_q;

    // stall released only in the done cycle
    assign core_stall_o = core_sel_i && (state_q != dcache_pkg::DONE);
    assign core_rdata_o = rdata_q;

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          core_sel_i,
    input  logic [dcache_pkg::ADDR_W-1:0] core_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] core_wdata_i,
    input  logic [dcache_pkg::MASK_W-1:0] core_mask_i,
    output logic [dcache_pkg::DATA_W-1:0] core_rdata_o,
    output logic                          core_stall_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                          mem_valid_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
    output logic [dcache_pkg::MASK_W-1:0] mem_wstrb_o,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                          mem_ready_i
);

    logic                            rd_en;
    logic [dcache_pkg::INDEX_W-1:0]  rd_index;
    logic [dcache_pkg::TAG_W-1:0]    rd_tag0;
    logic [dcache_pkg::TAG_W-1:0]    rd_tag1;
    logic [dcache_pkg::DATA_W-1:0]   rd_data0;
    logic [dcache_pkg::DATA_W-1:0]   rd_data1;

    logic [dcache_pkg::INDEX_W-1:0]  meta_index;
    logic                            meta_upd_way;
    logic                            meta_upd_valid;
    logic                            meta_upd_dirty;
    logic                            meta_dirty_val;
    logic                            meta_lru_upd;
    logic                            meta_lru_way;
    logic [dcache_pkg::NUM_WAYS-1:0] meta_valid;
    logic [dcache_pkg::NUM_WAYS-1:0] meta_dirty;
    logic                            meta_lru;

    // one write port per way
    sram_wr_if way0_wr_if ();
    sram_wr_if way1_wr_if ();

    dcache_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .core_sel_i       (core_sel_i),
        .core_addr_i      (core_addr_i),
        .core_wdata_i     (core_wdata_i),
        .core_mask_i      (core_mask_i),
        .core_rdata_o     (core_rdata_o),
        .core_stall_o     (core_stall_o),
        .mem_addr_o       (mem_addr_o),
        .mem_valid_o      (mem_valid_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_wstrb_o      (mem_wstrb_o),
        .mem_rdata_i      (mem_rdata_i),
        .mem_ready_i      (mem_ready_i),
        .way0_wr          (way0_wr_if.ctrl),
        .way1_wr          (way1_wr_if.ctrl),
        .rd_en_o          (rd_en),
        .rd_index_o       (rd_index),
        .rd_tag0_i        (rd_tag0),
        .rd_data0_i       (rd_data0),
        .rd_tag1_i        (rd_tag1),
        .rd_data1_i       (rd_data1),
        .meta_index_o     (meta_index),
        .meta_upd_way_o   (meta_upd_way),
        .meta_upd_valid_o (meta_upd_valid),
        .meta_upd_dirty_o (meta_upd_dirty),
        .meta_dirty_val_o (meta_dirty_val),
        .meta_lru_upd_o   (meta_lru_upd),
        .meta_lru_way_o   (meta_lru_way),
        .meta_valid_i     (meta_valid),
        .meta_dirty_i     (meta_dirty),
        .meta_lru_i       (meta_lru)
    );

    cache_way_ram u_way0 (
        .clk_i      (clk_i),
        .wr         (way0_wr_if.array),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_tag_o   (rd_tag0),
        .rd_data_o  (rd_data0)
    );

    cache_way_ram u_way1 (
        .clk_i      (clk_i),
        .wr         (way1_wr_if.array),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_tag_o   (rd_tag1),
        .rd_data_o  (rd_data1)
    );

    cache_meta u_meta (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .index_i     (meta_index),
        .upd_way_i   (meta_upd_way),
        .upd_valid_i (meta_upd_valid),
        .upd_dirty_i (meta_upd_dirty),
        .dirty_val_i (meta_dirty_val),
        .lru_upd_i   (meta_lru_upd),
        .lru_way_i   (meta_lru_way),
        .valid_o     (meta_valid),
        .dirty_o     (meta_dirty),
        .lru_o       (meta_lru)
    );

endmodule

// File: dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties (
    input logic                          clk_i,
    input logic                          rst_i,
    input logic                          core_sel_i,
    input logic                          core_stall_i,
    input logic                          mem_valid_i,
    input logic                          mem_ready_i,
    input logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
    input logic [dcache_pkg::DATA_W-1:0] mem_wdata_i,
    input logic [dcache_pkg::MASK_W-1:0] mem_wstrb_i,
    input logic                          way0_wr_en_i,
    input logic                          way1_wr_en_i
);

    // request held until the memory takes it
    mem_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_valid_i && !mem_ready_i) |=> (mem_valid_i && $stable(mem_addr_i) &&
                                           $stable(mem_wdata_i) && $stable(mem_wstrb_i)))
        else $error("memory request changed while waiting for ready");

    stall_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (core_sel_i && !core_stall_i) |=> !(core_sel_i && !core_stall_i))
        else $error("stall low for more than one cycle");

    // arrays are only written inside a request
    idle_no_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !core_sel_i |-> (!way0_wr_en_i && !way1_wr_en_i))
        else $error("way array written with no request pending");

endmodule

bind dcache_ctrl dcache_properties u_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_sel_i   (core_sel_i),
    .core_stall_i (core_stall_o),
    .mem_valid_i  (mem_valid_o),
    .mem_ready_i  (mem_ready_i),
    .mem_addr_i   (mem_addr_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_wstrb_i  (mem_wstrb_o),
    .way0_wr_en_i (way0_wr.wr_en),
    .way1_wr_en_i (way1_wr.wr_en)
);

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int ACCESS_TIMEOUT = 200;

    logic                          clk;
    logic                          rst;
    logic                          core_sel;
    logic [dcache_pkg::ADDR_W-1:0] core_addr;
    logic [dcache_pkg::DATA_W-1:0] core_wdata;
    logic [dcache_pkg::MASK_W-1:0] core_mask;
    logic [dcache_pkg::DATA_W-1:0] core_rdata;
    logic                          core_stall;
    logic [dcache_pkg::ADDR_W-1:0] mem_addr;
    logic                          mem_valid;
    logic [dcache_pkg::DATA_W-1:0] mem_wdata;
    logic [dcache_pkg::MASK_W-1:0] mem_wstrb;
    logic [dcache_pkg::DATA_W-1:0] mem_rdata;
    logic                          mem_ready;

    // backing memory and expected contents, both sparse
    logic [dcache_pkg::DATA_W-1:0] mem_store [logic [dcache_pkg::ADDR_W-1:0]];
    logic [dcache_pkg::DATA_W-1:0] ref_store [logic [dcache_pkg::ADDR_W-1:0]];

    int checks_run  = 0;
    int error_cnt   = 0;
    int timeout_cnt = 0;
    int mem_rd_cnt  = 0;
    int mem_wb_cnt  = 0;
    logic [dcache_pkg::ADDR_W-1:0] last_wb_addr;
    logic [dcache_pkg::DATA_W-1:0] last_wb_data;

    dcache_top dcache_top_inst (
        .clk_i        (clk),
        .rst_i        (rst),
        .core_sel_i   (core_sel),
        .core_addr_i  (core_addr),
        .core_wdata_i (core_wdata),
        .core_mask_i  (core_mask),
        .core_rdata_o (core_rdata),
        .core_stall_o (core_stall),
        .mem_addr_o   (mem_addr),
        .mem_valid_o  (mem_valid),
        .mem_wdata_o  (mem_wdata),
        .mem_wstrb_o  (mem_wstrb),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // untouched memory holds a pattern of its own address
    function automatic logic [31:0] fill_word(input logic [16:0] addr);
        return {addr, addr[14:0]} ^ 32'h3c5a_9617;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] mem_word(input logic [16:0] addr);
        if (mem_store.exists(addr)) begin
            return mem_store[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] ref_word(input logic [16:0] addr);
        if (ref_store.exists(addr)) begin
            return ref_store[addr];
        end
        return fill_word(addr);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks_run++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR %s", what);
        error_cnt++;
    endtask

    // memory port, answers after 0 to 5 idle cycles
    initial begin
        int  wait_left;
        bit  busy;
        mem_ready = 1'b0;
        mem_rdata = '0;
        wait_left = 0;
        busy      = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                mem_ready = 1'b0;
                busy      = 1'b0;
            end else if (!rst && mem_valid) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = int'($urandom % 6);
                end
                if (wait_left == 0) begin
                    if (mem_wstrb == '0) begin
                        mem_rdata = mem_word(mem_addr);
                        mem_rd_cnt++;
                    end else begin
                        check_value("mem_wstrb_o", 32'(mem_wstrb), 32'hf);
                        mem_store[mem_addr] = merge_bytes(mem_word(mem_addr), mem_wdata,
                                                          mem_wstrb);
                        last_wb_addr = mem_addr;
                        last_wb_data = mem_wdata;
                        mem_wb_cnt++;
                    end
                    mem_ready = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // one core request, held until stall falls
    task automatic cache_access(input logic [16:0] addr, input logic [31:0] wdata,
                                input logic [3:0] mask, output logic [31:0] rdata);
        int cycles;
        bit done;
        @(posedge clk);
        #1;
        core_sel   = 1'b1;
        core_addr  = addr;
        core_wdata = wdata;
        core_mask  = mask;
        cycles     = 0;
        done       = 1'b0;
        while (!done && cycles < ACCESS_TIMEOUT) begin
            @(negedge clk);
            if (!core_stall) begin
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        rdata = core_rdata;
        if (!done) begin
            $display("timeout: stall still high after %0d cycles, address 0x%05h",
                     ACCESS_TIMEOUT, addr);
            timeout_cnt++;
        end
        @(posedge clk);
        #1;
        core_sel  = 1'b0;
        core_mask = '0;
    endtask

    task automatic cache_write(input logic [16:0] addr, input logic [31:0] data,
                               input logic [3:0] mask);
        logic [31:0] ignored;
        ref_store[addr] = merge_bytes(ref_word(addr), data, mask);
        cache_access(addr, data, mask, ignored);
    endtask

    task automatic cache_read(input logic [16:0] addr, output logic [31:0] rdata);
        cache_access(addr, '0, '0, rdata);
    endtask

    function automatic logic [16:0] slot_addr(input int slot);
        logic [8:0] tag;
        logic [7:0] index;
        tag   = 9'h100 + 9'(slot / 2);
        index = 8'h80 + 8'(slot % 2);
        return {tag, index};
    endfunction

    task automatic idle_after_reset();
        @(negedge clk);
        check_value("mem_valid_o", 32'(mem_valid), 32'd0);
        check_value("core_stall_o", 32'(core_stall), 32'd0);
    endtask

    task automatic read_miss_then_hit();
        logic [16:0] addr;
        logic [31:0] rdata;
        int          rd_before;
        int          wb_before;
        addr      = {9'h012, 8'h10};
        rd_before = mem_rd_cnt;
        cache_read(addr, rdata);
        check_value("core_rdata_o", rdata, fill_word(addr));
        if (mem_rd_cnt != rd_before + 1) begin
            report_problem("read miss did not fetch exactly one word from memory");
        end
        rd_before = mem_rd_cnt;
        wb_before = mem_wb_cnt;
        cache_read(addr, rdata);
        check_value("core_rdata_o", rdata, fill_word(addr));
        if (mem_rd_cnt != rd_before || mem_wb_cnt != wb_before) begin
            report_problem("read hit went out to memory");
        end
    endtask

    task automatic full_word_write();
        logic [16:0] addr;
        logic [31:0] rdata;
        int          rd_before;
        int          wb_before;
        addr      = {9'h020, 8'h20};
        rd_before = mem_rd_cnt;
        wb_before = mem_wb_cnt;
        cache_write(addr, 32'hcafe_f00d, 4'hf);
        cache_read(addr, rdata);
        check_value("core_rdata_o", rdata, 32'hcafe_f00d);
        if (mem_rd_cnt != rd_before || mem_wb_cnt != wb_before) begin
            report_problem("full-word write and read back touched memory");
        end
    endtask

    task automatic byte_mask_writes();
        logic [16:0] addr;
        logic [31:0] rdata;
        int          rd_before;
        // single byte
        addr      = {9'h033, 8'h30};
        rd_before = mem_rd_cnt;
        cache_write(addr, 32'hdead_beef, 4'b0100);
        if (mem_rd_cnt != rd_before + 1) begin
            report_problem("single-byte write miss did not fetch the old word");
        end
        cache_read(addr, rdata);
        check_value("core_rdata_o", rdata, merge_bytes(fill_word(addr), 32'hdead_beef, 4'b0100));
        // half word
        addr      = {9'h034, 8'h31};
        rd_before = mem_rd_cnt;
        cache_write(addr, 32'h1234_5678, 4'b0011);
        if (mem_rd_cnt != rd_before + 1) begin
            report_problem("half-word write miss did not fetch the old word");
        end
        cache_read(addr, rdata);
        check_value("core_rdata_o", rdata, merge_bytes(fill_word(addr), 32'h1234_5678, 4'b0011));
    endtask

    task automatic lru_eviction();
        logic [16:0] addr1;
        logic [16:0] addr2;
        logic [16:0] addr3;
        logic [31:0] rdata;
        int          rd_before;
        int          wb_before;
        addr1 = {9'h021, 8'h40};
        addr2 = {9'h022, 8'h40};
        addr3 = {9'h023, 8'h40};
        cache_write(addr1, 32'h1111_aaaa, 4'hf);
        cache_write(addr2, 32'h2222_bbbb, 4'hf);
        // touching addr1 leaves addr2 as the older line
        cache_read(addr1, rdata);
        check_value("core_rdata_o", rdata, 32'h1111_aaaa);
        rd_before = mem_rd_cnt;
        wb_before = mem_wb_cnt;
        cache_write(addr3, 32'h3333_cccc, 4'hf);
        if (mem_wb_cnt != wb_before + 1 || mem_rd_cnt != rd_before) begin
            report_problem("third line in the set did not cause exactly one write-back");
        end
        check_value("mem_addr_o", 32'(last_wb_addr), 32'(addr2));
        check_value("mem_wdata_o", last_wb_data, 32'h2222_bbbb);
        // evicted line comes back from memory, pushing out addr1
        cache_read(addr2, rdata);
        check_value("core_rdata_o", rdata, ref_word(addr2));
        check_value("mem_addr_o", 32'(last_wb_addr), 32'(addr1));
        check_value("mem_wdata_o", last_wb_data, 32'h1111_aaaa);
    endtask

    task automatic random_traffic();
        logic [16:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        logic [31:0] rdata;
        int          slot;
        for (int n = 0; n < 200 && timeout_cnt == 0; n++) begin
            slot = int'($urandom % 16);
            addr = slot_addr(slot);
            data = $urandom;
            mask = 4'($urandom % 16);
            if ($urandom % 2 == 0) begin
                mask = '0;
            end
            if (mask == '0) begin
                cache_read(addr, rdata);
                check_value("core_rdata_o", rdata, ref_word(addr));
            end else begin
                cache_write(addr, data, mask);
            end
        end
        // final sweep over every address
        for (int s = 0; s < 16 && timeout_cnt == 0; s++) begin
            cache_read(slot_addr(s), rdata);
            check_value("core_rdata_o", rdata, ref_word(slot_addr(s)));
        end
    endtask

    initial begin
        void'($urandom(2));
        rst        = 1'b1;
        core_sel   = 1'b0;
        core_addr  = '0;
        core_wdata = '0;
        core_mask  = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_after_reset();
        if (timeout_cnt == 0) read_miss_then_hit();
        if (timeout_cnt == 0) full_word_write();
        if (timeout_cnt == 0) byte_mask_writes();
        if (timeout_cnt == 0) lru_eviction();
        if (timeout_cnt == 0) random_traffic();
        $display("%0d checks, %0d errors, %0d timeouts", checks_run, error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
dcache_pkg.sv
dcache_if.sv
cache_way_ram.sv
cache_meta.sv
dcache_ctrl.sv
dcache_top.sv
dcache_properties.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcache -f tb.f -o tb_dcache_sim

./obj_dir/tb_dcache_sim | tee sim.log

if grep -q "^All tests passed$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
